// ==== design/vga_pkg.sv ====
package vga_pkg;

	// Glyph geometry in font pixels
	localparam int unsigned FONT_W = 8;
	localparam int unsigned FONT_H = 8;

	// Font counters also cover the spacing column and line
	localparam int unsigned FCOL_W  = $clog2(FONT_W + 1);
	localparam int unsigned FLINE_W = $clog2(FONT_H + 1);

	localparam int unsigned CODE_W     = 7;
	localparam int unsigned ROM_ADDR_W = 10; // Code in upper bits, glyph line in lower

	typedef logic [2:0] color_t; // One bit each for R, G, B
	typedef logic [3:0] scale_t; // 1 to 15, zero never stored
	typedef logic [CODE_W-1:0] code_t;
	typedef logic [7:0] idx_t; // Character column or row

	// AXI4-Lite register offsets
	typedef enum logic [11:0] {
		REG_CTRL      = 12'h000,
		REG_PALETTE   = 12'h004,
		REG_SCALE     = 12'h008,
		REG_SELECT    = 12'h00C,
		REG_TEXT_BASE = 12'h100 // One word per character from here
	} reg_addr_e;

	// Per-channel handshake state
	typedef enum logic [1:0] {
		IDLE,
		RESP
	} axil_state_e;

endpackage

// ==== design/vga_ifs.sv ====
`timescale 1ns/1ps

// Held config registers, no handshake
interface cfg_if;
	import vga_pkg::*;

	logic enable;
	color_t text;
	color_t bg;
	color_t sel;
	color_t sel_bg;
	scale_t pix_w;
	scale_t pix_h;
	idx_t sel_row;
	logic sel_en;

	modport regs (output enable, text, bg, sel, sel_bg, pix_w, pix_h, sel_row, sel_en);
	modport timing (input pix_w, pix_h);
	modport shade (input enable, text, bg, sel, sel_bg, sel_row, sel_en);
endinterface

// Screen position straight from the counters
interface scan_if #(
	parameter int ADDR_W = 12
);
	import vga_pkg::*;

	logic active;
	logic hsync;
	logic vsync;
	idx_t col;
	idx_t row;
	logic [FCOL_W-1:0] font_col;
	logic [FLINE_W-1:0] font_line;
	logic [ADDR_W-1:0] cell_addr; // row * TEXT_COLS + col

	modport src (output active, hsync, vsync, col, row, font_col, font_line, cell_addr);
	modport dst (input active, hsync, vsync, col, row, font_col, font_line, cell_addr);
endinterface

// Position delayed to line up with rom_q
interface glyph_if;
	import vga_pkg::*;

	logic active;
	logic hsync;
	logic vsync;
	logic [FCOL_W-1:0] font_col;
	logic [FLINE_W-1:0] font_line;
	idx_t char_row;

	modport src (output active, hsync, vsync, font_col, font_line, char_row);
	modport dst (input active, hsync, vsync, font_col, font_line, char_row);
endinterface

// ==== design/axil_cfg_regs.sv ====
`timescale 1ns/1ps

module axil_cfg_regs #(
	parameter int TEXT_COLS = 64,
	parameter int TEXT_ROWS = 48
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [31:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [31:0] wdata,
	input  logic [3:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [31:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	cfg_if.regs cfg,
	output logic wr_en,
	output logic [$clog2(TEXT_COLS*TEXT_ROWS)-1:0] wr_addr,
	output vga_pkg::code_t wr_code
);
	import vga_pkg::*;

	localparam int DEPTH = TEXT_COLS * TEXT_ROWS;
	localparam int AW = $clog2(DEPTH);

	axil_state_e w_state;
	axil_state_e r_state;
	logic wr_accept;
	logic ar_accept;
	logic in_text;
	logic [31:0] text_off;
	logic [31:0] rd_word;

	function automatic logic [31:0] reg_word(input reg_addr_e r);
		return {20'd0, r};
	endfunction

	function automatic scale_t fix_scale(input logic [3:0] v);
		return (v == 4'd0) ? 4'd1 : v;
	endfunction

	// Both beats must arrive together, wstrb ignored
	assign wr_accept = (w_state == IDLE) && awvalid && wvalid;
	assign awready = wr_accept;
	assign wready = wr_accept;
	assign bvalid = (w_state == RESP);
	assign bresp = 2'b00;
	assign rvalid = (r_state == RESP);
	assign rresp = 2'b00;
	assign ar_accept = arready && arvalid;

	assign text_off = awaddr - reg_word(REG_TEXT_BASE);
	assign in_text = (awaddr >= reg_word(REG_TEXT_BASE)) && (awaddr[1:0] == 2'b00) &&
		((text_off >> 2) < 32'(DEPTH));

	// Write channel and config registers
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			w_state <= IDLE;
			cfg.enable <= 1'b0;
			cfg.text <= 3'd7;
			cfg.bg <= 3'd0;
			cfg.sel <= 3'd0;
			cfg.sel_bg <= 3'd6;
			cfg.pix_w <= 4'd1;
			cfg.pix_h <= 4'd1;
			cfg.sel_row <= '0;
			cfg.sel_en <= 1'b0;
		end else begin
			case (w_state)
				IDLE: if (wr_accept) w_state <= RESP;
				RESP: if (bready) w_state <= IDLE; // Stalls only this channel
				default: w_state <= IDLE;
			endcase
			if (wr_accept) begin
				if (awaddr == reg_word(REG_CTRL)) begin
					cfg.enable <= wdata[0];
				end
				if (awaddr == reg_word(REG_PALETTE)) begin
					cfg.text <= wdata[2:0];
					cfg.bg <= wdata[6:4];
					cfg.sel <= wdata[10:8];
					cfg.sel_bg <= wdata[14:12];
				end
				if (awaddr == reg_word(REG_SCALE)) begin
					cfg.pix_w <= fix_scale(wdata[3:0]);
					cfg.pix_h <= fix_scale(wdata[11:8]);
				end
				if (awaddr == reg_word(REG_SELECT)) begin
					cfg.sel_row <= wdata[7:0];
					cfg.sel_en <= wdata[8];
				end
			end
		end
	end

	// Character buffer write, one cycle after acceptance
	always_ff @(posedge clk) begin
		if (!rst_n) wr_en <= 1'b0;
		else wr_en <= wr_accept && in_text;
	end

	always_ff @(posedge clk) begin
		wr_addr <= AW'(text_off >> 2);
		wr_code <= wdata[CODE_W-1:0];
	end

	// Read mux, text window and holes read as 0
	always_comb begin
		rd_word = '0;
		if (araddr == reg_word(REG_CTRL)) rd_word = {31'd0, cfg.enable};
		if (araddr == reg_word(REG_PALETTE))
			rd_word = {17'd0, cfg.sel_bg, 1'b0, cfg.sel, 1'b0, cfg.bg, 1'b0, cfg.text};
		if (araddr == reg_word(REG_SCALE)) rd_word = {20'd0, cfg.pix_h, 4'd0, cfg.pix_w};
		if (araddr == reg_word(REG_SELECT)) rd_word = {23'd0, cfg.sel_en, cfg.sel_row};
	end

	// Read channel
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			r_state <= IDLE;
			arready <= 1'b0;
		end else begin
			case (r_state)
				IDLE: begin
					if (ar_accept) begin
						r_state <= RESP;
						arready <= 1'b0;
					end else begin
						arready <= 1'b1;
					end
				end
				RESP: begin
					if (rready) begin
						r_state <= IDLE;
						arready <= 1'b1;
					end
				end
				default: r_state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ar_accept) rdata <= rd_word;
	end

endmodule

// ==== design/text_buffer.sv ====
`timescale 1ns/1ps

module text_buffer #(
	parameter int DEPTH = 3072
) (
	input  logic clk,
	input  logic wr_en,
	input  logic [$clog2(DEPTH)-1:0] wr_addr,
	input  vga_pkg::code_t wr_code,
	input  logic [$clog2(DEPTH)-1:0] rd_addr,
	output vga_pkg::code_t rd_code
);
	import vga_pkg::*;

	code_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (wr_en) mem[wr_addr] <= wr_code;
	end

	// One cycle read latency, part of the fixed video delay
	always_ff @(posedge clk) begin
		rd_code <= mem[rd_addr];
	end

endmodule

// ==== design/scan_timing.sv ====
`timescale 1ns/1ps

module scan_timing #(
	parameter int RES_H = 640,
	parameter int RES_V = 480,
	parameter int H_FP = 16,
	parameter int H_SYNC = 96,
	parameter int H_BP = 48,
	parameter int V_FP = 10,
	parameter int V_SYNC = 2,
	parameter int V_BP = 33,
	parameter int TEXT_COLS = 64,
	parameter int TEXT_ROWS = 48
) (
	input  logic clk,
	input  logic rst_n,
	cfg_if.timing cfg,
	scan_if.src scan
);
	import vga_pkg::*;

	localparam int H_TOTAL = RES_H + H_FP + H_SYNC + H_BP;
	localparam int V_TOTAL = RES_V + V_FP + V_SYNC + V_BP;
	localparam int HW = $clog2(H_TOTAL);
	localparam int VW = $clog2(V_TOTAL);
	localparam int ADDR_W = $clog2(TEXT_COLS * TEXT_ROWS);

	localparam logic [HW-1:0] H_VIS = HW'(RES_H);
	localparam logic [HW-1:0] H_SYNC_ON = HW'(RES_H + H_FP);
	localparam logic [HW-1:0] H_SYNC_OFF = HW'(RES_H + H_FP + H_SYNC);
	localparam logic [HW-1:0] H_LAST = HW'(H_TOTAL - 1);
	localparam logic [VW-1:0] V_VIS = VW'(RES_V);
	localparam logic [VW-1:0] V_SYNC_ON = VW'(RES_V + V_FP);
	localparam logic [VW-1:0] V_SYNC_OFF = VW'(RES_V + V_FP + V_SYNC);
	localparam logic [VW-1:0] V_LAST = VW'(V_TOTAL - 1);
	localparam logic [FCOL_W-1:0] FCOL_LAST = FCOL_W'(FONT_W); // Spacing column
	localparam logic [FLINE_W-1:0] FLINE_LAST = FLINE_W'(FONT_H); // Spacing line
	localparam idx_t COL_END = idx_t'(TEXT_COLS);
	localparam idx_t ROW_END = idx_t'(TEXT_ROWS);

	logic [HW-1:0] h_cnt;
	logic [VW-1:0] v_cnt;
	logic h_vis;
	logic v_vis;
	logic line_end;
	scale_t sub_x;
	scale_t sub_y;
	logic [FCOL_W-1:0] font_col;
	logic [FLINE_W-1:0] font_line;
	idx_t col;
	idx_t row;

	assign h_vis = (h_cnt < H_VIS);
	assign v_vis = (v_cnt < V_VIS);
	assign line_end = (h_cnt == H_LAST);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (line_end) begin
			h_cnt <= '0;
			v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// Horizontal cell position, restarts every line
	always_ff @(posedge clk) begin
		if (!rst_n || line_end) begin
			sub_x <= '0;
			font_col <= '0;
			col <= '0;
		end else if (h_vis) begin
			if (sub_x >= cfg.pix_w - 1'b1) begin // >= copes with a scale change mid-line
				sub_x <= '0;
				if (font_col == FCOL_LAST) begin
					font_col <= '0;
					if (col != COL_END) col <= col + 1'b1; // Parks past the grid
				end else begin
					font_col <= font_col + 1'b1;
				end
			end else begin
				sub_x <= sub_x + 1'b1;
			end
		end
	end

	// Vertical cell position, steps once per line
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sub_y <= '0;
			font_line <= '0;
			row <= '0;
		end else if (line_end) begin
			if (v_cnt == V_LAST) begin
				sub_y <= '0;
				font_line <= '0;
				row <= '0;
			end else if (v_vis) begin
				if (sub_y >= cfg.pix_h - 1'b1) begin
					sub_y <= '0;
					if (font_line == FLINE_LAST) begin
						font_line <= '0;
						if (row != ROW_END) row <= row + 1'b1;
					end else begin
						font_line <= font_line + 1'b1;
					end
				end else begin
					sub_y <= sub_y + 1'b1;
				end
			end
		end
	end

	assign scan.active = h_vis && v_vis && (col < COL_END) && (row < ROW_END);
	assign scan.hsync = (h_cnt >= H_SYNC_ON) && (h_cnt < H_SYNC_OFF);
	assign scan.vsync = (v_cnt >= V_SYNC_ON) && (v_cnt < V_SYNC_OFF);
	assign scan.col = col;
	assign scan.row = row;
	assign scan.font_col = font_col;
	assign scan.font_line = font_line;
	assign scan.cell_addr = ADDR_W'(row * TEXT_COLS + col); // Don't care off the grid

endmodule

// ==== design/glyph_fetch.sv ====
`timescale 1ns/1ps

module glyph_fetch #(
	parameter int DEPTH = 3072
) (
	input  logic clk,
	input  logic rst_n,
	scan_if.dst scan,
	output logic [$clog2(DEPTH)-1:0] rd_addr,
	input  vga_pkg::code_t rd_code,
	output logic [vga_pkg::ROM_ADDR_W-1:0] rom_addr,
	glyph_if.src glyph
);
	import vga_pkg::*;

	localparam int LINE_W = ROM_ADDR_W - CODE_W;

	// Stage 1 registers line up with rd_code
	logic act_d;
	logic hs_d;
	logic vs_d;
	logic [FCOL_W-1:0] col_d;
	logic [FLINE_W-1:0] line_d;
	idx_t row_d;
	logic [LINE_W-1:0] rom_line;

	assign rd_addr = scan.cell_addr;

	// Low bits of the spacing line are zero so it reads line 0
	assign rom_line = line_d[LINE_W-1:0];
	assign rom_addr = {rd_code, rom_line};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			act_d <= 1'b0;
			hs_d <= 1'b0;
			vs_d <= 1'b0;
			glyph.active <= 1'b0;
			glyph.hsync <= 1'b0;
			glyph.vsync <= 1'b0;
		end else begin
			act_d <= scan.active;
			hs_d <= scan.hsync;
			vs_d <= scan.vsync;
			glyph.active <= act_d; // Stage 2 lines up with rom_q
			glyph.hsync <= hs_d;
			glyph.vsync <= vs_d;
		end
	end

	always_ff @(posedge clk) begin
		col_d <= scan.font_col;
		line_d <= scan.font_line;
		row_d <= scan.row;
		glyph.font_col <= col_d;
		glyph.font_line <= line_d;
		glyph.char_row <= row_d;
	end

endmodule

// ==== design/pixel_shader.sv ====
`timescale 1ns/1ps

module pixel_shader (
	input  logic clk,
	input  logic rst_n,
	cfg_if.shade cfg,
	glyph_if.dst glyph,
	input  logic [vga_pkg::FONT_W-1:0] rom_q,
	output vga_pkg::color_t rgb,
	output logic hsync,
	output logic vsync
);
	import vga_pkg::*;

	localparam int BIT_W = $clog2(FONT_W);

	logic in_glyph;
	logic [BIT_W-1:0] bit_idx;
	logic fg;
	logic on_sel;
	color_t color;

	// Spacing column and line fall outside the glyph
	assign in_glyph = (glyph.font_col < FCOL_W'(FONT_W)) && (glyph.font_line < FLINE_W'(FONT_H));
	assign bit_idx = BIT_W'(FONT_W - 1) - glyph.font_col[BIT_W-1:0]; // MSB is leftmost
	assign fg = glyph.active && in_glyph && rom_q[bit_idx];
	assign on_sel = cfg.sel_en && (glyph.char_row == cfg.sel_row);

	always_comb begin
		if (on_sel) color = fg ? cfg.sel : cfg.sel_bg;
		else color = fg ? cfg.text : cfg.bg;
		if (!cfg.enable || !glyph.active) color = '0; // Blanking and off-grid
	end

	// All three pins leave on the same edge
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rgb <= '0;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end else begin
			rgb <= color;
			hsync <= glyph.hsync;
			vsync <= glyph.vsync;
		end
	end

endmodule

// ==== design/vga_text_top.sv ====
`timescale 1ns/1ps

module vga_text_top #(
	parameter int RES_H = 640,
	parameter int RES_V = 480,
	parameter int H_FP = 16,
	parameter int H_SYNC = 96,
	parameter int H_BP = 48,
	parameter int V_FP = 10,
	parameter int V_SYNC = 2,
	parameter int V_BP = 33,
	parameter int TEXT_COLS = 64,
	parameter int TEXT_ROWS = 48
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [31:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [31:0] wdata,
	input  logic [3:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [31:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	output logic [vga_pkg::ROM_ADDR_W-1:0] rom_addr,
	input  logic [vga_pkg::FONT_W-1:0] rom_q,
	output vga_pkg::color_t rgb,
	output logic hsync,
	output logic vsync
);
	import vga_pkg::*;

	localparam int DEPTH = TEXT_COLS * TEXT_ROWS;
	localparam int ADDR_W = $clog2(DEPTH);

	logic wr_en;
	logic [ADDR_W-1:0] wr_addr;
	logic [ADDR_W-1:0] rd_addr;
	code_t wr_code;
	code_t rd_code;

	cfg_if cfg0 ();
	scan_if #(.ADDR_W(ADDR_W)) scan0 ();
	glyph_if glyph0 ();

	axil_cfg_regs #(
		.TEXT_COLS(TEXT_COLS),
		.TEXT_ROWS(TEXT_ROWS)
	) regs0 (
		.clk(clk), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.cfg(cfg0.regs),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_code(wr_code)
	);

	text_buffer #(.DEPTH(DEPTH)) buf0 (
		.clk(clk),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_code(wr_code),
		.rd_addr(rd_addr), .rd_code(rd_code)
	);

	scan_timing #(
		.RES_H(RES_H), .RES_V(RES_V),
		.H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
		.V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
		.TEXT_COLS(TEXT_COLS), .TEXT_ROWS(TEXT_ROWS)
	) timing0 (
		.clk(clk), .rst_n(rst_n),
		.cfg(cfg0.timing),
		.scan(scan0.src)
	);

	// Buffer read plus ROM read, two cycles
	glyph_fetch #(.DEPTH(DEPTH)) fetch0 (
		.clk(clk), .rst_n(rst_n),
		.scan(scan0.dst),
		.rd_addr(rd_addr), .rd_code(rd_code),
		.rom_addr(rom_addr),
		.glyph(glyph0.src)
	);

	pixel_shader shade0 (
		.clk(clk), .rst_n(rst_n),
		.cfg(cfg0.shade),
		.glyph(glyph0.dst),
		.rom_q(rom_q),
		.rgb(rgb), .hsync(hsync), .vsync(vsync)
	);

endmodule

// ==== sim/tb_vga_text.sv ====
`timescale 1ns/1ps

module tb_vga_text;

	localparam int RES_H = 40;
	localparam int RES_V = 24;
	localparam int H_FP = 2;
	localparam int H_SYNC = 4;
	localparam int H_BP = 2;
	localparam int V_FP = 1;
	localparam int V_SYNC = 2;
	localparam int V_BP = 1;
	localparam int TEXT_COLS = 4;
	localparam int TEXT_ROWS = 2;

	localparam int H_TOTAL = RES_H + H_FP + H_SYNC + H_BP;
	localparam int V_TOTAL = RES_V + V_FP + V_SYNC + V_BP;
	localparam int FRAME = H_TOTAL * V_TOTAL;
	localparam int CELLS = TEXT_COLS * TEXT_ROWS;
	localparam int FONT_W = 8;
	localparam int FONT_H = 8;
	localparam int N_ENTRIES = 5;
	localparam int TIMEOUT_NS = N_ENTRIES * 2 * FRAME * 8 + 40000;

	localparam logic [31:0] A_CTRL = 32'h000;
	localparam logic [31:0] A_PAL = 32'h004;
	localparam logic [31:0] A_SCL = 32'h008;
	localparam logic [31:0] A_SEL = 32'h00C;
	localparam logic [31:0] A_TEXT = 32'h100;

	// Words written and the values expected back
	typedef struct packed {
		logic [31:0] ctrl;
		logic [31:0] pal;
		logic [31:0] scl;
		logic [31:0] sel;
		logic [31:0] exp_pal;
		logic [31:0] exp_scl;
		logic [31:0] exp_sel;
	} entry_t;

	localparam entry_t ENTRIES [N_ENTRIES] = '{
		'{32'h1, 32'h6007, 32'h0000, 32'h000, 32'h6007, 32'h0101, 32'h000}, // Zero scale reads as 1
		'{32'h1, 32'h3521, 32'h0302, 32'h000, 32'h3521, 32'h0302, 32'h000}, // 2 by 3 cells
		'{32'h1, 32'h4635, 32'h0101, 32'h101, 32'h4635, 32'h0101, 32'h101}, // Row 1 selected
		'{32'h1, 32'h9ABC, 32'hF2F1, 32'h100, 32'h1234, 32'h0201, 32'h100},
		'{32'h0, 32'h1234, 32'h0101, 32'h000, 32'h1234, 32'h0101, 32'h000}  // Disabled
	};

	logic clk = 1'b0;
	logic rst_n;
	logic [31:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [31:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [9:0] rom_addr;
	logic [7:0] rom_q = 8'h00;
	logic [2:0] rgb;
	logic hsync;
	logic vsync;

	logic [6:0] codes [CELLS]; // Shadow of the character buffer
	logic [7:0] rom_word;

	vga_text_top #(
		.RES_H(RES_H), .RES_V(RES_V),
		.H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
		.V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
		.TEXT_COLS(TEXT_COLS), .TEXT_ROWS(TEXT_ROWS)
	) dut0 (.*);

	always #4 clk = ~clk;

	// Glyph byte is code XOR line times 0x25
	function automatic logic [7:0] glyph_byte(input logic [6:0] code, input logic [2:0] line);
		logic [7:0] mult;
		mult = 8'h25 * {5'd0, line};
		return {1'b0, code} ^ mult;
	endfunction

	// Synchronous font ROM
	always @(posedge clk) begin
		rom_word = glyph_byte(rom_addr[9:3], rom_addr[2:0]);
		#1;
		rom_q = rom_word;
	end

	// Expected color of visible pixel (x, y)
	function automatic logic [2:0] pixel_color(input int x, input int y, input entry_t e);
		int pw;
		int ph;
		int col;
		int row;
		int fc;
		int fl;
		logic [7:0] g;
		logic fg;
		pw = int'(e.exp_scl[3:0]);
		ph = int'(e.exp_scl[11:8]);
		col = x / ((FONT_W + 1) * pw);
		row = y / ((FONT_H + 1) * ph);
		fc = (x % ((FONT_W + 1) * pw)) / pw;
		fl = (y % ((FONT_H + 1) * ph)) / ph;
		if (!e.ctrl[0] || col >= TEXT_COLS || row >= TEXT_ROWS) return 3'd0;
		fg = 1'b0;
		if (fc < FONT_W && fl < FONT_H) begin // Spacing column and line stay background
			g = glyph_byte(codes[row * TEXT_COLS + col], 3'(fl));
			fg = g[FONT_W - 1 - fc];
		end
		if (e.exp_sel[8] && row == int'(e.exp_sel[7:0]))
			return fg ? e.exp_pal[10:8] : e.exp_pal[14:12];
		return fg ? e.exp_pal[2:0] : e.exp_pal[6:4];
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (got !== exp) begin
			$display("Fail %s exp %h got %h", name, exp, got);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
		@(posedge clk);
		#1;
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		@(negedge clk);
		while (!(awready && wready)) @(negedge clk);
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b1;
		@(negedge clk);
		check_val("bvalid", 32'd1, 32'(bvalid)); // Rises the cycle after acceptance
		check_val("bresp", 32'd0, 32'(bresp));
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
		@(posedge clk);
		#1;
		araddr = addr;
		arvalid = 1'b1;
		@(negedge clk);
		while (!arready) @(negedge clk);
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		rready = 1'b1;
		@(negedge clk);
		check_val("rvalid", 32'd1, 32'(rvalid));
		check_val("rresp", 32'd0, 32'(rresp));
		data = rdata;
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	// One full frame at the pins starting at a vsync falling edge
	task automatic compare_frame(input entry_t e);
		logic prev;
		int i;
		int p;
		int h;
		int v;
		logic [2:0] exp_rgb;
		@(negedge clk);
		prev = vsync;
		@(negedge clk);
		while (!(prev === 1'b1 && vsync === 1'b0)) begin
			prev = vsync;
			@(negedge clk);
		end
		for (i = 0; i < FRAME; i++) begin
			p = ((RES_V + V_FP + V_SYNC) * H_TOTAL + i) % FRAME; // Falling edge is line start
			h = p % H_TOTAL;
			v = p / H_TOTAL;
			exp_rgb = (h < RES_H && v < RES_V) ? pixel_color(h, v, e) : 3'd0;
			check_val($sformatf("hsync x %0d y %0d", h, v),
				32'(h >= RES_H + H_FP && h < RES_H + H_FP + H_SYNC), 32'(hsync));
			check_val($sformatf("vsync x %0d y %0d", h, v),
				32'(v >= RES_V + V_FP && v < RES_V + V_FP + V_SYNC), 32'(vsync));
			check_val($sformatf("rgb x %0d y %0d", h, v), 32'(exp_rgb), 32'(rgb));
			@(negedge clk);
		end
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout after %0d ns, the DUT stopped answering or no frame started", TIMEOUT_NS);
		$display("SIMULATION FAILED");
		$fatal(1);
	end

	initial begin
		logic [31:0] rd;
		int i;
		int k;
		rst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'hF;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		void'($urandom(32'he5e1));

		@(posedge clk);
		@(negedge clk);
		check_val("awready", 32'd0, 32'(awready));
		check_val("wready", 32'd0, 32'(wready));
		check_val("arready", 32'd0, 32'(arready));
		check_val("bvalid", 32'd0, 32'(bvalid));
		check_val("rvalid", 32'd0, 32'(rvalid));
		check_val("hsync", 32'd0, 32'(hsync));
		check_val("vsync", 32'd0, 32'(vsync));
		check_val("rgb", 32'd0, 32'(rgb));
		@(posedge clk);
		#1;
		rst_n = 1'b1;

		// Reset values
		read_word(A_CTRL, rd);
		check_val("rdata CTRL", 32'h0, rd);
		read_word(A_PAL, rd);
		check_val("rdata PALETTE", 32'h6007, rd);
		read_word(A_SCL, rd);
		check_val("rdata SCALE", 32'h0101, rd);
		read_word(A_SEL, rd);
		check_val("rdata SELECT", 32'h0, rd);

		write_word(A_CTRL, 32'h1);
		read_word(A_CTRL, rd);
		check_val("rdata CTRL", 32'h1, rd);
		write_word(A_PAL, 32'h9ABC); // Gap bits dropped
		read_word(A_PAL, rd);
		check_val("rdata PALETTE", 32'h1234, rd);
		write_word(A_SCL, 32'h0F0F);
		read_word(A_SCL, rd);
		check_val("rdata SCALE", 32'h0F0F, rd);
		write_word(A_SEL, 32'h1FF);
		read_word(A_SEL, rd);
		check_val("rdata SELECT", 32'h1FF, rd);

		// Random codes with junk in the upper data bits
		for (i = 0; i < CELLS; i++) begin
			codes[i] = 7'($urandom());
			write_word(A_TEXT + 32'(4 * i), {25'h1FFFFFF, codes[i]});
		end
		// Past the window where a truncated index would hit cell 0
		write_word(A_TEXT + 32'(4 * CELLS), {25'd0, ~codes[0]});

		read_word(A_TEXT + 32'h4, rd);
		check_val("rdata text window", 32'h0, rd);
		read_word(32'h010, rd);
		check_val("rdata unmapped", 32'h0, rd);
		read_word(32'h200, rd);
		check_val("rdata unmapped", 32'h0, rd);

		// Read response held while a write goes through
		@(posedge clk);
		#1;
		araddr = A_PAL;
		arvalid = 1'b1;
		@(negedge clk);
		while (!arready) @(negedge clk);
		@(posedge clk);
		#1;
		araddr = A_SCL; // Next read waits behind the held response
		write_word(A_SCL, 32'h0203);
		repeat (3) begin
			@(negedge clk);
			check_val("rvalid", 32'd1, 32'(rvalid));
			check_val("arready", 32'd0, 32'(arready));
			check_val("rdata", 32'h1234, rdata);
		end
		@(posedge clk);
		#1;
		rready = 1'b1;
		@(negedge clk);
		while (!arready) @(negedge clk);
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		@(negedge clk);
		check_val("rvalid", 32'd1, 32'(rvalid));
		check_val("rdata", 32'h0203, rdata);
		@(posedge clk);
		#1;
		rready = 1'b0;

		// Write response held while a read goes through
		@(posedge clk);
		#1;
		awaddr = A_SEL;
		wdata = 32'h003;
		awvalid = 1'b1;
		wvalid = 1'b1;
		@(negedge clk);
		while (!awready) @(negedge clk);
		@(posedge clk);
		#1;
		wdata = 32'h005;
		read_word(A_SEL, rd);
		check_val("rdata SELECT", 32'h003, rd);
		repeat (3) begin
			@(negedge clk);
			check_val("bvalid", 32'd1, 32'(bvalid));
			check_val("awready", 32'd0, 32'(awready));
		end
		@(posedge clk);
		#1;
		bready = 1'b1;
		@(negedge clk);
		while (!awready) @(negedge clk);
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		@(negedge clk);
		check_val("bvalid", 32'd1, 32'(bvalid));
		@(posedge clk);
		#1;
		bready = 1'b0;
		read_word(A_SEL, rd);
		check_val("rdata SELECT", 32'h005, rd);

		for (k = 0; k < N_ENTRIES; k++) begin
			write_word(A_CTRL, ENTRIES[k].ctrl);
			write_word(A_PAL, ENTRIES[k].pal);
			write_word(A_SCL, ENTRIES[k].scl);
			write_word(A_SEL, ENTRIES[k].sel);
			read_word(A_CTRL, rd);
			check_val("rdata CTRL", {31'd0, ENTRIES[k].ctrl[0]}, rd);
			read_word(A_PAL, rd);
			check_val("rdata PALETTE", ENTRIES[k].exp_pal, rd);
			read_word(A_SCL, rd);
			check_val("rdata SCALE", ENTRIES[k].exp_scl, rd);
			read_word(A_SEL, rd);
			check_val("rdata SELECT", ENTRIES[k].exp_sel, rd);
			compare_frame(ENTRIES[k]);
		end

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== flist.f ====
design/vga_pkg.sv
design/vga_ifs.sv
design/axil_cfg_regs.sv
design/text_buffer.sv
design/scan_timing.sv
design/glyph_fetch.sv
design/pixel_shader.sv
design/vga_text_top.sv
sim/tb_vga_text.sv

// ==== Makefile ====
TOP = tb_vga_text
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f flist.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
